/* Makefile */
TOP := tb_pyramid

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* bench/pyramid_props.sv */
`timescale 1ns/10ps

module pyramid_props (
    input logic clk_100mhz,
    input logic sys_rst,
    input logic txd_i,
    input logic level_ready_i,
    input logic tx_busy_i
);

    // no transfer running means the line sits at mark
    a_line_idle: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        !tx_busy_i |-> txd_i)
        else $error("uart_txd_o went low while no level transfer was running");

    a_ready_sticky: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        level_ready_i |=> level_ready_i)
        else $error("level_ready_o fell without a reset");

    // only a finished level can be sent
    a_busy_needs_ready: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
        tx_busy_i |-> level_ready_i)
        else $error("tx_busy_o high while level_ready_o is low");

endmodule

bind pyramid_top pyramid_props u_props (
    .clk_100mhz    (clk_100mhz),
    .sys_rst       (sys_rst),
    .txd_i         (uart_txd_o),
    .level_ready_i (level_ready_o),
    .tx_busy_i     (tx_busy_o)
);

/* bench/tb_pyramid.sv */
`timescale 1ns/10ps

module tb_pyramid;

    localparam int IMG_W          = 8;
    localparam int IMG_H          = 8;
    localparam int BAUD           = 8;
    localparam int NUM_PIX        = IMG_W * IMG_H;
    localparam int NUM_LVL        = (IMG_W / 2) * (IMG_H / 2);
    localparam int FRAME_CYC      = 10 * BAUD;                // start, 8 data, stop
    localparam int START_TIMEOUT  = 4 * FRAME_CYC;
    localparam int REDUCE_TIMEOUT = 8 * NUM_LVL + 100;
    localparam int TX_IDLE_WAIT   = 2 * BAUD;
    // 64 bytes in and 32 bytes out, doubled, plus margin
    localparam int WATCHDOG_CYC   = (NUM_PIX + 2 * NUM_LVL) * FRAME_CYC * 2 + 2000;

    logic clk_100mhz;
    logic sys_rst;
    logic uart_rxd;
    logic send;
    logic uart_txd;
    logic image_received;
    logic level_ready;
    logic tx_busy;

    pyramid_pkg::pixel_t image [NUM_PIX];
    pyramid_pkg::pixel_t expected [NUM_LVL];
    integer              seed;

    pyramid_top #(
        .IMG_WIDTH     (IMG_W),
        .IMG_HEIGHT    (IMG_H),
        .CLKS_PER_BAUD (BAUD)
    ) u_dut (
        .clk_100mhz       (clk_100mhz),
        .sys_rst          (sys_rst),
        .uart_rxd_i       (uart_rxd),
        .send_i           (send),
        .uart_txd_o       (uart_txd),
        .image_received_o (image_received),
        .level_ready_o    (level_ready),
        .tx_busy_o        (tx_busy)
    );

    initial clk_100mhz = 1'b0;
    always #5 clk_100mhz = ~clk_100mhz;                       // 100 MHz

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // 8N1 frame, lsb first, each bit held one baud period
    task automatic uart_send_byte(input pyramid_pkg::pixel_t b);
        @(posedge clk_100mhz);
        uart_rxd <= 1'b0;
        repeat (BAUD) @(posedge clk_100mhz);
        for (int i = 0; i < 8; i++) begin
            uart_rxd <= b[i];
            repeat (BAUD) @(posedge clk_100mhz);
        end
        uart_rxd <= 1'b1;
        repeat (BAUD) @(posedge clk_100mhz);
    endtask

    task automatic pulse_send();
        @(posedge clk_100mhz);
        send <= 1'b1;
        @(posedge clk_100mhz);
        send <= 1'b0;
    endtask

    // finds the start bit, then samples each bit near its middle
    task automatic uart_recv_byte(output pyramid_pkg::pixel_t b);
        int waited;
        waited = 0;
        b      = '0;
        @(negedge clk_100mhz);
        while (uart_txd !== 1'b0) begin
            if (waited == START_TIMEOUT) begin
                $display("timeout at %0t ns: no start bit came on uart_txd_o", $time);
                abort_run();
            end
            waited++;
            @(negedge clk_100mhz);
        end
        repeat (BAUD / 2) @(negedge clk_100mhz);
        check_value("start bit", 32'(uart_txd), 32'd0);
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD) @(negedge clk_100mhz);
            b[i] = uart_txd;
        end
        repeat (BAUD) @(negedge clk_100mhz);
        check_value("stop bit", 32'(uart_txd), 32'd1);
    endtask

    // 2x2 box mean, truncated
    task automatic compute_reference();
        int base;
        int acc;
        for (int oy = 0; oy < IMG_H / 2; oy++) begin
            for (int ox = 0; ox < IMG_W / 2; ox++) begin
                base = 2 * oy * IMG_W + 2 * ox;
                acc  = int'(image[base]) + int'(image[base + 1])
                     + int'(image[base + IMG_W]) + int'(image[base + IMG_W + 1]);
                expected[oy * (IMG_W / 2) + ox] = pyramid_pkg::pixel_t'(acc / 4);
            end
        end
    endtask

    task automatic expect_line_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_100mhz);
            check_value("uart_txd_o while idle", 32'(uart_txd), 32'd1);
            check_value("tx_busy_o while idle", 32'(tx_busy), 32'd0);
        end
    endtask

    task automatic wait_level_ready();
        int waited;
        waited = 0;
        @(negedge clk_100mhz);
        while (level_ready !== 1'b1) begin
            if (waited == REDUCE_TIMEOUT) begin
                $display("timeout at %0t ns: level_ready_o never rose", $time);
                abort_run();
            end
            waited++;
            @(negedge clk_100mhz);
        end
    endtask

    task automatic wait_tx_idle();
        int waited;
        waited = 0;
        @(negedge clk_100mhz);
        while (tx_busy !== 1'b0) begin
            if (waited == TX_IDLE_WAIT) begin
                $display("timeout at %0t ns: tx_busy_o stayed high after the level", $time);
                abort_run();
            end
            waited++;
            @(negedge clk_100mhz);
        end
    endtask

    // resend_after < 0 means no extra send pulse
    task automatic receive_level(input int resend_after);
        pyramid_pkg::pixel_t got;
        for (int i = 0; i < NUM_LVL; i++) begin
            uart_recv_byte(got);
            check_value($sformatf("level pixel %0d", i), 32'(got), 32'(expected[i]));
            check_value($sformatf("tx_busy_o in stop bit of pixel %0d", i),
                        32'(tx_busy), 32'd1);                // covers the whole level
            if (i == resend_after) begin
                pulse_send();
            end
        end
    endtask

    task automatic reset_outputs_idle();
        @(negedge clk_100mhz);
        check_value("uart_txd_o after reset", 32'(uart_txd), 32'd1);
        check_value("image_received_o after reset", 32'(image_received), 32'd0);
        check_value("level_ready_o after reset", 32'(level_ready), 32'd0);
        check_value("tx_busy_o after reset", 32'(tx_busy), 32'd0);
    endtask

    task automatic early_send_ignored();
        pulse_send();
        expect_line_idle(2 * FRAME_CYC);
    endtask

    task automatic image_load_flags();
        for (int i = 0; i < NUM_PIX; i++) begin
            uart_send_byte(image[i]);
            @(negedge clk_100mhz);
            check_value($sformatf("image_received_o after byte %0d", i),
                        32'(image_received), (i == NUM_PIX - 1) ? 32'd1 : 32'd0);
        end
        wait_level_ready();
    endtask

    task automatic first_level_transfer();
        pulse_send();
        receive_level(-1);
        wait_tx_idle();
    endtask

    task automatic repeat_level_transfer();
        pulse_send();
        receive_level(5);                                   // extra pulse mid transfer
        wait_tx_idle();
        expect_line_idle(2 * FRAME_CYC);
    endtask

    task automatic extra_bytes_ignored();
        for (int i = 0; i < 4; i++) begin
            uart_send_byte(pyramid_pkg::pixel_t'($random(seed)));
        end
        @(negedge clk_100mhz);
        check_value("image_received_o after extra bytes", 32'(image_received), 32'd1);
        check_value("level_ready_o after extra bytes", 32'(level_ready), 32'd1);
        pulse_send();
        receive_level(-1);
        wait_tx_idle();
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_100mhz);
        $display("watchdog expired at %0t ns: the tests ran far too long", $time);
        abort_run();
    end

    initial begin
        seed     = 32'h9bcc_ffb6;
        sys_rst  = 1'b1;
        uart_rxd = 1'b1;                                    // line idles high
        send     = 1'b0;
        for (int i = 0; i < NUM_PIX; i++) begin
            image[i] = pyramid_pkg::pixel_t'($random(seed));
        end
        compute_reference();

        repeat (5) @(posedge clk_100mhz);
        sys_rst <= 1'b0;

        reset_outputs_idle();
        early_send_ignored();
        image_load_flags();
        first_level_transfer();
        repeat_level_transfer();
        extra_bytes_ignored();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* common/frame_mem_if.sv */
`timescale 1ns/10ps

interface frame_mem_if #(
    parameter int ADDR_W = 12
);

    logic               wr_en;
    logic [ADDR_W-1:0]  wr_addr;
    pyramid_pkg::pixel_t wr_data;
    logic [ADDR_W-1:0]  rd_addr;
    pyramid_pkg::pixel_t rd_data;                  // valid one cycle after rd_addr

    modport writer (output wr_en, output wr_addr, output wr_data);

    modport reader (output rd_addr, input rd_data);

    modport mem (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

/* common/pyramid_pkg.sv */
package pyramid_pkg;

    localparam int PIXEL_W = 8;                    // greyscale depth, also one UART byte

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [PIXEL_W+1:0] pix_sum_t;         // room for four pixels

    // reducer walks each 2x2 block through these
    typedef enum logic [2:0] {
        RED_IDLE,
        RED_READ,
        RED_ACCUM,
        RED_WRITE,
        RED_DONE
    } reduce_state_e;

    typedef enum logic [1:0] {
        SND_IDLE,
        SND_FETCH,
        SND_LAUNCH,
        SND_WAIT_TX
    } send_state_e;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

endpackage

/* hdl/image_loader.sv */
`timescale 1ns/10ps

module image_loader #(
    parameter int NUM_PIXELS = 4096
) (
    input  logic                clk_100mhz,
    input  logic                sys_rst,
    input  pyramid_pkg::pixel_t rx_data_i,
    input  logic                rx_valid_i,
    frame_mem_if.writer         wr_if,
    output logic                image_received_o,
    output logic                reduce_start_o
);

    localparam int ADDR_W = $clog2(NUM_PIXELS);

    logic [ADDR_W-1:0] wr_ptr;
    logic              full;
    logic              accept;

    assign accept = rx_valid_i && !full;           // bytes past a full image are dropped

    assign wr_if.wr_en   = accept;
    assign wr_if.wr_addr = wr_ptr;
    assign wr_if.wr_data = rx_data_i;

    assign image_received_o = full;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            wr_ptr         <= '0;
            full           <= 1'b0;
            reduce_start_o <= 1'b0;
        end else begin
            reduce_start_o <= 1'b0;
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_ptr == ADDR_W'(NUM_PIXELS - 1)) begin
                    full           <= 1'b1;
                    reduce_start_o <= 1'b1;  // single pulse, full blocks a repeat
                end
            end
        end
    end

endmodule

/* hdl/level_sender.sv */
`timescale 1ns/10ps

module level_sender #(
    parameter int NUM_PIXELS = 1024
) (
    input  logic                clk_100mhz,
    input  logic                sys_rst,
    input  logic                send_i,
    input  logic                level_ready_i,
    frame_mem_if.reader         rd_if,
    input  logic                tx_busy_i,
    output pyramid_pkg::pixel_t tx_data_o,
    output logic                tx_start_o,
    output logic                busy_o
);

    localparam int ADDR_W = $clog2(NUM_PIXELS);

    pyramid_pkg::send_state_e state;
    logic [ADDR_W-1:0]        rd_ptr;
    logic                     send_q;
    logic                     send_rise;

    assign send_rise = send_i && !send_q;

    // rd_ptr is steady through LAUNCH, so rd_data holds the pixel
    assign rd_if.rd_addr = rd_ptr;
    assign tx_data_o     = rd_if.rd_data;
    assign tx_start_o    = (state == pyramid_pkg::SND_LAUNCH) && !tx_busy_i;
    assign busy_o        = (state != pyramid_pkg::SND_IDLE);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state  <= pyramid_pkg::SND_IDLE;
            rd_ptr <= '0;
            send_q <= 1'b0;
        end else begin
            send_q <= send_i;
            case (state)
                pyramid_pkg::SND_IDLE: begin
                    if (send_rise && level_ready_i) begin
                        rd_ptr <= '0;
                        state  <= pyramid_pkg::SND_FETCH;
                    end
                end
                pyramid_pkg::SND_FETCH: state <= pyramid_pkg::SND_LAUNCH;  // memory latency
                pyramid_pkg::SND_LAUNCH: begin
                    if (!tx_busy_i) begin
                        state <= pyramid_pkg::SND_WAIT_TX;
                    end
                end
                pyramid_pkg::SND_WAIT_TX: begin
                    // uart_tx raises busy on the cycle after the start
                    if (!tx_busy_i) begin
                        if (rd_ptr == ADDR_W'(NUM_PIXELS - 1)) begin
                            state <= pyramid_pkg::SND_IDLE;
                        end else begin
                            rd_ptr <= rd_ptr + 1'b1;
                            state  <= pyramid_pkg::SND_FETCH;
                        end
                    end
                end
                default: state <= pyramid_pkg::SND_IDLE;
            endcase
        end
    end

endmodule

/* hdl/pyramid_top.sv */
`timescale 1ns/10ps

module pyramid_top #(
    parameter int IMG_WIDTH     = 64,
    parameter int IMG_HEIGHT    = 64,
    parameter int CLKS_PER_BAUD = 50
) (
    input  logic clk_100mhz,
    input  logic sys_rst,
    input  logic uart_rxd_i,
    input  logic send_i,
    output logic uart_txd_o,
    output logic image_received_o,
    output logic level_ready_o,
    output logic tx_busy_o
);

    localparam int NUM_SRC = IMG_WIDTH * IMG_HEIGHT;
    localparam int NUM_LVL = (IMG_WIDTH / 2) * (IMG_HEIGHT / 2);
    localparam int SRC_AW  = $clog2(NUM_SRC);
    localparam int LVL_AW  = $clog2(NUM_LVL);

    pyramid_pkg::pixel_t rx_data;
    logic                rx_valid;
    logic                reduce_start;
    pyramid_pkg::pixel_t tx_data;
    logic                tx_start;
    logic                tx_busy;                  // uart_tx only, one byte

    frame_mem_if #(.ADDR_W(SRC_AW)) src_mem ();
    frame_mem_if #(.ADDR_W(LVL_AW)) lvl_mem ();

    uart_rx #(.CLKS_PER_BAUD(CLKS_PER_BAUD)) u_uart_rx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .rxd_i      (uart_rxd_i),
        .data_o     (rx_data),
        .valid_o    (rx_valid)
    );

    image_loader #(.NUM_PIXELS(NUM_SRC)) u_loader (
        .clk_100mhz       (clk_100mhz),
        .sys_rst          (sys_rst),
        .rx_data_i        (rx_data),
        .rx_valid_i       (rx_valid),
        .wr_if            (src_mem.writer),
        .image_received_o (image_received_o),
        .reduce_start_o   (reduce_start)
    );

    frame_buffer #(.ADDR_W(SRC_AW)) u_src_buf (
        .clk_100mhz (clk_100mhz),
        .mem_if     (src_mem.mem)
    );

    pyramid_reduce #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) u_reduce (
        .clk_100mhz    (clk_100mhz),
        .sys_rst       (sys_rst),
        .start_i       (reduce_start),
        .src_if        (src_mem.reader),
        .lvl_if        (lvl_mem.writer),
        .level_ready_o (level_ready_o)
    );

    frame_buffer #(.ADDR_W(LVL_AW)) u_lvl_buf (
        .clk_100mhz (clk_100mhz),
        .mem_if     (lvl_mem.mem)
    );

    level_sender #(.NUM_PIXELS(NUM_LVL)) u_sender (
        .clk_100mhz    (clk_100mhz),
        .sys_rst       (sys_rst),
        .send_i        (send_i),
        .level_ready_i (level_ready_o),
        .rd_if         (lvl_mem.reader),
        .tx_busy_i     (tx_busy),
        .tx_data_o     (tx_data),
        .tx_start_o    (tx_start),
        .busy_o        (tx_busy_o)              // spans the whole level transfer
    );

    uart_tx #(.CLKS_PER_BAUD(CLKS_PER_BAUD)) u_uart_tx (
        .clk_100mhz (clk_100mhz),
        .sys_rst    (sys_rst),
        .data_i     (tx_data),
        .start_i    (tx_start),
        .txd_o      (uart_txd_o),
        .busy_o     (tx_busy)
    );

endmodule

/* pyramid/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer #(
    parameter int ADDR_W = 12
) (
    input  logic           clk_100mhz,
    frame_mem_if.mem       mem_if
);

    pyramid_pkg::pixel_t mem [2**ADDR_W];

    always_ff @(posedge clk_100mhz) begin
        if (mem_if.wr_en) begin
            mem[mem_if.wr_addr] <= mem_if.wr_data;
        end
        mem_if.rd_data <= mem[mem_if.rd_addr];     // read-first, one cycle latency
    end

endmodule

/* pyramid/pyramid_reduce.sv */
`timescale 1ns/10ps

module pyramid_reduce #(
    parameter int IMG_WIDTH  = 64,
    parameter int IMG_HEIGHT = 64
) (
    input  logic       clk_100mhz,
    input  logic       sys_rst,
    input  logic       start_i,
    frame_mem_if.reader src_if,
    frame_mem_if.writer lvl_if,
    output logic       level_ready_o
);

    localparam int OUT_W  = IMG_WIDTH / 2;
    localparam int OUT_H  = IMG_HEIGHT / 2;
    localparam int SRC_AW = $clog2(IMG_WIDTH * IMG_HEIGHT);
    localparam int LVL_AW = $clog2(OUT_W * OUT_H);
    localparam int X_W    = $clog2(OUT_W);
    localparam int Y_W    = $clog2(OUT_H);

    pyramid_pkg::reduce_state_e state;
    logic [X_W-1:0]             out_x;
    logic [Y_W-1:0]             out_y;
    logic [LVL_AW-1:0]          out_idx;
    logic [1:0]                 quad;              // {row, col} inside the 2x2 block
    logic                       data_vld;
    pyramid_pkg::pix_sum_t      sum;
    logic [Y_W:0]               src_row;
    logic [X_W:0]               src_col;

    assign src_row = {out_y, quad[1]};
    assign src_col = {out_x, quad[0]};
    assign src_if.rd_addr = SRC_AW'(src_row * IMG_WIDTH + src_col);

    assign lvl_if.wr_en   = (state == pyramid_pkg::RED_WRITE);
    assign lvl_if.wr_addr = out_idx;
    assign lvl_if.wr_data = pyramid_pkg::pixel_t'(sum >> 2);    // truncated mean

    assign level_ready_o = (state == pyramid_pkg::RED_DONE);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state    <= pyramid_pkg::RED_IDLE;
            out_x    <= '0;
            out_y    <= '0;
            out_idx  <= '0;
            quad     <= '0;
            data_vld <= 1'b0;
        end else begin
            data_vld <= (state == pyramid_pkg::RED_READ);   // rd_data lands next cycle
            case (state)
                pyramid_pkg::RED_IDLE: begin
                    if (start_i) begin
                        out_x   <= '0;
                        out_y   <= '0;
                        out_idx <= '0;
                        quad    <= '0;
                        state   <= pyramid_pkg::RED_READ;
                    end
                end
                pyramid_pkg::RED_READ: begin
                    quad <= quad + 1'b1;           // wraps back to 0 after the fourth
                    if (quad == 2'd3) begin
                        state <= pyramid_pkg::RED_ACCUM;
                    end
                end
                pyramid_pkg::RED_ACCUM: state <= pyramid_pkg::RED_WRITE;   // last pixel in
                pyramid_pkg::RED_WRITE: begin
                    out_idx <= out_idx + 1'b1;
                    state   <= pyramid_pkg::RED_READ;
                    if (out_x == X_W'(OUT_W - 1)) begin
                        out_x <= '0;
                        if (out_y == Y_W'(OUT_H - 1)) begin
                            state <= pyramid_pkg::RED_DONE;
                        end else begin
                            out_y <= out_y + 1'b1;
                        end
                    end else begin
                        out_x <= out_x + 1'b1;
                    end
                end
                pyramid_pkg::RED_DONE: state <= pyramid_pkg::RED_DONE;     // held until reset
                default: state <= pyramid_pkg::RED_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (state == pyramid_pkg::RED_IDLE || state == pyramid_pkg::RED_WRITE) begin
            sum <= '0;
        end else if (data_vld) begin
            sum <= sum + pyramid_pkg::pix_sum_t'(src_if.rd_data);
        end
    end

endmodule

/* sources.f */
common/pyramid_pkg.sv
common/frame_mem_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
pyramid/frame_buffer.sv
pyramid/pyramid_reduce.sv
hdl/image_loader.sv
hdl/level_sender.sv
hdl/pyramid_top.sv
bench/pyramid_props.sv
bench/tb_pyramid.sv

/* uart/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BAUD = 50
) (
    input  logic                clk_100mhz,
    input  logic                sys_rst,
    input  logic                rxd_i,
    output pyramid_pkg::pixel_t data_o,
    output logic                valid_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BAUD);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(CLKS_PER_BAUD - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BAUD / 2 - 1);

    pyramid_pkg::uart_state_e state;
    logic                     rxd_meta;
    logic                     rxd_sync;
    logic [CNT_W-1:0]         baud_cnt;
    logic [2:0]               bit_idx;
    pyramid_pkg::pixel_t      shreg;

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            rxd_meta <= 1'b1;                      // line idles high
            rxd_sync <= 1'b1;
            state    <= pyramid_pkg::UART_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            valid_o  <= 1'b0;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            valid_o  <= 1'b0;
            case (state)
                pyramid_pkg::UART_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (!rxd_sync) begin
                        state <= pyramid_pkg::UART_START;
                    end
                end
                pyramid_pkg::UART_START: begin
                    if (baud_cnt == HALF_LAST) begin   // middle of start bit
                        baud_cnt <= '0;
                        // a glitch shorter than half a bit goes back to idle
                        state    <= rxd_sync ? pyramid_pkg::UART_IDLE : pyramid_pkg::UART_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                pyramid_pkg::UART_DATA: begin
                    if (baud_cnt == BAUD_LAST) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= pyramid_pkg::UART_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                pyramid_pkg::UART_STOP: begin
                    if (baud_cnt == BAUD_LAST) begin
                        state   <= pyramid_pkg::UART_IDLE;
                        valid_o <= rxd_sync;           // framing error drops the byte
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= pyramid_pkg::UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (state == pyramid_pkg::UART_DATA && baud_cnt == BAUD_LAST) begin
            shreg <= {rxd_sync, shreg[7:1]};       // lsb first
        end
        if (state == pyramid_pkg::UART_STOP && baud_cnt == BAUD_LAST) begin
            data_o <= shreg;
        end
    end

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BAUD = 50
) (
    input  logic                clk_100mhz,
    input  logic                sys_rst,
    input  pyramid_pkg::pixel_t data_i,
    input  logic                start_i,
    output logic                txd_o,
    output logic                busy_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BAUD);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(CLKS_PER_BAUD - 1);

    pyramid_pkg::uart_state_e state;
    logic [CNT_W-1:0]         baud_cnt;
    logic [2:0]               bit_idx;
    pyramid_pkg::pixel_t      shreg;

    assign busy_o = (state != pyramid_pkg::UART_IDLE);

    always_ff @(posedge clk_100mhz) begin
        if (sys_rst) begin
            state    <= pyramid_pkg::UART_IDLE;
            txd_o    <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                pyramid_pkg::UART_IDLE: begin
                    txd_o    <= 1'b1;
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (start_i) begin
                        txd_o <= 1'b0;             // start bit on the next cycle
                        state <= pyramid_pkg::UART_START;
                    end
                end
                pyramid_pkg::UART_START: begin
                    if (baud_cnt == BAUD_LAST) begin
                        baud_cnt <= '0;
                        txd_o    <= shreg[0];
                        state    <= pyramid_pkg::UART_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                pyramid_pkg::UART_DATA: begin
                    if (baud_cnt == BAUD_LAST) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            txd_o <= 1'b1;         // stop bit
                            state <= pyramid_pkg::UART_STOP;
                        end else begin
                            txd_o <= shreg[0];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                pyramid_pkg::UART_STOP: begin
                    if (baud_cnt == BAUD_LAST) begin
                        state <= pyramid_pkg::UART_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= pyramid_pkg::UART_IDLE;
            endcase
        end
    end

    // shreg[0] always holds the next bit to go out
    always_ff @(posedge clk_100mhz) begin
        if (state == pyramid_pkg::UART_IDLE && start_i) begin
            shreg <= data_i;
        end else if (state != pyramid_pkg::UART_IDLE && state != pyramid_pkg::UART_STOP
                     && baud_cnt == BAUD_LAST) begin
            shreg <= shreg >> 1;
        end
    end

endmodule
